//--- rtl/ex_pkg.sv
// Shared types of the integer execute stage. Widths follow RV32 and a
// 64-entry register space (integer and floating-point registers)
package ex_pkg;

  ////////////////////
  // Widths
  ////////////////////

  localparam int unsigned XLEN          = 32;
  localparam int unsigned RF_ADDR_WIDTH = 6;

  typedef logic [XLEN-1:0] word_t;

  // Data word with its taint bit
  typedef struct packed {
    word_t data;
    logic  tag;
  } tagged_word_t;

  ////////////////////
  // Operators
  ////////////////////

  typedef enum logic [4:0] {
    ALU_ADD  = 5'd0,
    ALU_SUB  = 5'd1,
    ALU_AND  = 5'd2,
    ALU_OR   = 5'd3,
    ALU_XOR  = 5'd4,
    ALU_SLL  = 5'd5,
    ALU_SRL  = 5'd6,
    ALU_SRA  = 5'd7,
    ALU_SLT  = 5'd8,
    ALU_SLTU = 5'd9,
    // Branch comparisons
    ALU_EQ   = 5'd10,
    ALU_NE   = 5'd11,
    ALU_LT   = 5'd12,
    ALU_GE   = 5'd13,
    ALU_LTU  = 5'd14,
    ALU_GEU  = 5'd15
  } alu_op_e;

  typedef enum logic [1:0] {
    MULT_MUL    = 2'd0,
    MULT_MULH   = 2'd1,
    MULT_MULHSU = 2'd2,
    MULT_MULHU  = 2'd3
  } mult_op_e;

  ////////////////////
  // Requests and ports
  ////////////////////

  // Operand c carries the jump target
  typedef struct packed {
    logic         enable;
    alu_op_e      op;
    tagged_word_t a;
    tagged_word_t b;
    tagged_word_t c;
  } alu_req_t;

  typedef struct packed {
    logic         enable;
    mult_op_e     op;
    tagged_word_t a;
    tagged_word_t b;
  } mult_req_t;

  // One register-file write
  typedef struct packed {
    logic                     we;
    logic [RF_ADDR_WIDTH-1:0] addr;
    word_t                    data;
    logic                     tag;
  } rf_wr_t;

  typedef struct packed {
    word_t data;
    logic  tag;
  } lsu_rsp_t;

endpackage

//--- rtl/ex_alu.sv
// Single-cycle integer ALU, no divider, so never busy
// Shift amount is the low five bits of operand b
module ex_alu import ex_pkg::*; (
  input  alu_req_t req_i,
  output word_t    result_o,
  output logic     cmp_result_o
);

  word_t             op_a;
  word_t             op_b;
  logic signed [XLEN-1:0] op_a_signed;
  logic [4:0]        shamt;

  logic              is_sub;
  word_t             adder_b;
  word_t             adder_result;

  logic              equal;
  logic              signed_lt;
  logic              unsigned_lt;
  logic              cmp;

  assign op_a        = req_i.a.data;
  assign op_b        = req_i.b.data;
  assign op_a_signed = $signed(req_i.a.data);
  assign shamt       = req_i.b.data[4:0];

  ////////////////////
  // Adder
  ////////////////////

  // Subtract by inverting b and carrying in one
  assign is_sub       = (req_i.op == ALU_SUB);
  assign adder_b      = is_sub ? ~op_b : op_b;
  assign adder_result = op_a + adder_b + word_t'(is_sub);

  ////////////////////
  // Comparator
  ////////////////////

  assign equal       = (op_a == op_b);
  assign signed_lt   = ($signed(op_a) < $signed(op_b));
  assign unsigned_lt = (op_a < op_b);

  // SLT and SLTU count as comparisons too
  always_comb begin
    cmp = 1'b0;
    unique case (req_i.op)
      ALU_EQ:           cmp = equal;
      ALU_NE:           cmp = ~equal;
      ALU_LT, ALU_SLT:  cmp = signed_lt;
      ALU_GE:           cmp = ~signed_lt;
      ALU_LTU, ALU_SLTU: cmp = unsigned_lt;
      ALU_GEU:          cmp = ~unsigned_lt;
      default:          cmp = 1'b0;
    endcase
  end

  assign cmp_result_o = cmp;

  ////////////////////
  // Result mux
  ////////////////////

  always_comb begin
    result_o = '0;
    unique case (req_i.op)
      ALU_ADD, ALU_SUB: result_o = adder_result;
      ALU_AND:          result_o = op_a & op_b;
      ALU_OR:           result_o = op_a | op_b;
      ALU_XOR:          result_o = op_a ^ op_b;
      ALU_SLL:          result_o = op_a << shamt;
      ALU_SRL:          result_o = op_a >> shamt;
      // Arithmetic shift keeps the sign of a
      ALU_SRA:          result_o = word_t'(op_a_signed >>> shamt);
      // Comparisons give the compare bit, zero-extended
      ALU_SLT, ALU_SLTU,
      ALU_EQ, ALU_NE,
      ALU_LT, ALU_GE,
      ALU_LTU, ALU_GEU: result_o = {{(XLEN-1){1'b0}}, cmp};
      default:          result_o = '0;
    endcase
  end

endmodule

//--- rtl/ex_mult.sv
// MUL is combinational; the high products take three cycles and need the
// request held stable until the final state is left on ex_ready_i
module ex_mult import ex_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  mult_req_t req_i,
  input  logic      ex_ready_i,
  output word_t     result_o,
  output logic      ready_o,
  output logic      multicycle_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_STEP,
    ST_FINISH
  } mult_state_e;

  mult_state_e state_q;
  mult_state_e state_d;

  logic high_op;
  logic a_signed;
  logic b_signed;

  logic signed [XLEN:0]     a_ext;
  logic signed [XLEN/2:0]   b_lo_ext;
  logic signed [XLEN/2:0]   b_hi_ext;
  logic signed [XLEN+16:0]  pp_lo_d;
  logic signed [XLEN+16:0]  pp_lo_q;
  logic signed [XLEN+17:0]  pp_hi;
  logic signed [2*XLEN-1:0] prod_full;
  word_t                    prod_low;

  assign high_op  = (req_i.op != MULT_MUL);
  assign a_signed = (req_i.op == MULT_MULH) || (req_i.op == MULT_MULHSU);
  assign b_signed = (req_i.op == MULT_MULH);

  // Operand extension, 33 bits for a and 17 bits per half of b
  assign a_ext    = {a_signed & req_i.a.data[XLEN-1], req_i.a.data};
  assign b_lo_ext = {1'b0, req_i.b.data[15:0]};
  assign b_hi_ext = {b_signed & req_i.b.data[XLEN-1], req_i.b.data[XLEN-1:16]};

  ////////////////////
  // Datapath
  ////////////////////

  // Low product for MUL
  assign prod_low = req_i.a.data * req_i.b.data;

  // Partial product with the low half of b, kept for FINISH
  assign pp_lo_d = a_ext * b_lo_ext;

  always_ff @(posedge clk) begin
    if (state_q == ST_STEP) begin
      pp_lo_q <= pp_lo_d;
    end
  end

  // High half of b, shifted into place
  assign pp_hi     = a_ext * b_hi_ext;
  assign prod_full = (pp_hi <<< 16) + pp_lo_q;

  assign multicycle_o = (state_q == ST_FINISH);
  assign result_o     = multicycle_o ? prod_full[2*XLEN-1:XLEN] : prod_low;

  ////////////////////
  // Control FSM
  ////////////////////

  always_comb begin
    state_d = state_q;
    ready_o = 1'b1;
    unique case (state_q)
      ST_IDLE: begin
        if (req_i.enable && high_op) begin
          ready_o = 1'b0;
          state_d = ST_STEP;
        end
      end
      ST_STEP: begin
        ready_o = 1'b0;
        state_d = ST_FINISH;
      end
      // Hold the high word until EX can hand it on
      ST_FINISH: begin
        if (ex_ready_i) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Decode must not change a high product in flight
  assert property (@(posedge clk) disable iff (!rst_n)
    (state_q != ST_IDLE) |-> ($stable(req_i.op) && $stable(req_i.a) && $stable(req_i.b)))
    else $error("multiplier request changed while busy");

endmodule

//--- rtl/ex_tag_prop.sv
// Taint of the forwarded result; CSR reads are never tainted
module ex_tag_prop import ex_pkg::*; (
  input  alu_req_t  alu_req_i,
  input  mult_req_t mult_req_i,
  input  logic      csr_access_i,
  output logic      tag_o
);

  logic alu_shift;
  logic alu_tag;
  logic mult_tag;

  // Shift ops, the amount in b carries no taint
  assign alu_shift = (alu_req_i.op == ALU_SLL) ||
                     (alu_req_i.op == ALU_SRL) ||
                     (alu_req_i.op == ALU_SRA);

  assign alu_tag  = alu_shift ? alu_req_i.a.tag
                              : (alu_req_i.a.tag | alu_req_i.b.tag);
  assign mult_tag = mult_req_i.a.tag | mult_req_i.b.tag;

  ////////////////////
  // Priority
  ////////////////////

  always_comb begin
    tag_o = 1'b0;
    if (csr_access_i) begin
      tag_o = 1'b0;
    end else if (mult_req_i.enable) begin
      tag_o = mult_tag;
    end else if (alu_req_i.enable) begin
      tag_o = alu_tag;
    end
  end

endmodule

//--- rtl/ex_writeback.sv
// Forwarding-port mux, EX/WB register of the load port and stall control
// Load data and tag come live from the LSU in the WB cycle
module ex_writeback import ex_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,

  input  logic                     alu_en_i,
  input  logic                     mult_en_i,
  input  logic                     csr_access_i,
  input  logic                     lsu_en_i,

  input  word_t                    alu_result_i,
  input  word_t                    mult_result_i,
  input  word_t                    csr_rdata_i,
  input  logic                     tag_i,

  input  logic                     regfile_alu_we_i,
  input  logic [RF_ADDR_WIDTH-1:0] regfile_alu_waddr_i,
  input  logic                     regfile_we_i,
  input  logic [RF_ADDR_WIDTH-1:0] regfile_waddr_i,

  input  lsu_rsp_t                 lsu_rsp_i,
  input  logic                     lsu_ready_ex_i,
  input  logic                     lsu_err_i,
  input  logic                     mult_ready_i,
  input  logic                     branch_in_ex_i,
  input  logic                     wb_ready_i,

  output rf_wr_t                   fw_o,
  output rf_wr_t                   wb_o,
  output logic                     ex_ready_o,
  output logic                     ex_valid_o
);

  logic                     lsu_we_q;
  logic [RF_ADDR_WIDTH-1:0] lsu_waddr_q;
  logic                     units_ready;

  ////////////////////
  // Forwarding port
  ////////////////////

  // CSR data wins over the multiplier, which wins over the ALU
  always_comb begin
    fw_o.we   = regfile_alu_we_i;
    fw_o.addr = regfile_alu_waddr_i;
    fw_o.tag  = tag_i;
    if (csr_access_i) begin
      fw_o.data = csr_rdata_i;
    end else if (mult_en_i) begin
      fw_o.data = mult_result_i;
    end else begin
      fw_o.data = alu_result_i;
    end
  end

  ////////////////////
  // EX/WB register
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lsu_we_q <= 1'b0;
    end else if (ex_valid_o) begin
      lsu_we_q <= regfile_we_i & ~lsu_err_i;
    end else if (wb_ready_i) begin
      // Nothing new arrives, so drain the slot
      lsu_we_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_valid_o && regfile_we_i && !lsu_err_i) begin
      lsu_waddr_q <= regfile_waddr_i;
    end
  end

  always_comb begin
    wb_o.we   = lsu_we_q;
    wb_o.addr = lsu_waddr_q;
    wb_o.data = lsu_rsp_i.data;
    wb_o.tag  = lsu_rsp_i.tag;
  end

  ////////////////////
  // Stall control
  ////////////////////

  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;

  // Branches finish in EX, so ready ignores WB for them
  assign ex_ready_o = units_ready | branch_in_ex_i;
  assign ex_valid_o = (alu_en_i | mult_en_i | csr_access_i | lsu_en_i) & units_ready;

  assert property (@(posedge clk) disable iff (!rst_n) ex_valid_o |-> wb_ready_i)
    else $error("EX valid without WB ready");

endmodule

//--- rtl/ex_stage.sv
// Integer execute stage with taint tracking, no APU and no divider
// Decode holds all inputs stable while ex_ready_o is low
module ex_stage import ex_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,

  // Requests from decode
  input  alu_req_t                 alu_req_i,
  input  mult_req_t                mult_req_i,

  input  logic                     csr_access_i,
  input  word_t                    csr_rdata_i,

  input  logic                     lsu_en_i,
  input  logic                     lsu_ready_ex_i,
  input  logic                     lsu_err_i,
  input  lsu_rsp_t                 lsu_rsp_i,

  input  logic                     branch_in_ex_i,

  input  logic                     regfile_alu_we_i,
  input  logic [RF_ADDR_WIDTH-1:0] regfile_alu_waddr_i,
  input  logic                     regfile_we_i,
  input  logic [RF_ADDR_WIDTH-1:0] regfile_waddr_i,

  input  logic                     wb_ready_i,

  // Register-file write ports
  output rf_wr_t                   regfile_fw_o,
  output rf_wr_t                   regfile_wb_o,

  // To fetch
  output word_t                    jump_target_o,
  output logic                     branch_decision_o,

  output logic                     mult_multicycle_o,
  output logic                     ex_ready_o,
  output logic                     ex_valid_o
);

  word_t alu_result;
  logic  alu_cmp_result;
  word_t mult_result;
  logic  mult_ready;
  logic  tag_result;

  // Branch target and decision
  assign jump_target_o     = alu_req_i.c.data;
  assign branch_decision_o = alu_cmp_result;

  ////////////////////
  // Units
  ////////////////////

  ex_alu i_ex_alu (
    .req_i        ( alu_req_i      ),
    .result_o     ( alu_result     ),
    .cmp_result_o ( alu_cmp_result )
  );

  ex_mult i_ex_mult (
    .clk          ( clk               ),
    .rst_n        ( rst_n             ),
    .req_i        ( mult_req_i        ),
    .ex_ready_i   ( ex_ready_o        ),
    .result_o     ( mult_result       ),
    .ready_o      ( mult_ready        ),
    .multicycle_o ( mult_multicycle_o )
  );

  ex_tag_prop i_ex_tag_prop (
    .alu_req_i    ( alu_req_i    ),
    .mult_req_i   ( mult_req_i   ),
    .csr_access_i ( csr_access_i ),
    .tag_o        ( tag_result   )
  );

  ////////////////////
  // Write ports and stalls
  ////////////////////

  ex_writeback i_ex_writeback (
    .clk                 ( clk                 ),
    .rst_n               ( rst_n               ),
    .alu_en_i            ( alu_req_i.enable    ),
    .mult_en_i           ( mult_req_i.enable   ),
    .csr_access_i        ( csr_access_i        ),
    .lsu_en_i            ( lsu_en_i            ),
    .alu_result_i        ( alu_result          ),
    .mult_result_i       ( mult_result         ),
    .csr_rdata_i         ( csr_rdata_i         ),
    .tag_i               ( tag_result          ),
    .regfile_alu_we_i    ( regfile_alu_we_i    ),
    .regfile_alu_waddr_i ( regfile_alu_waddr_i ),
    .regfile_we_i        ( regfile_we_i        ),
    .regfile_waddr_i     ( regfile_waddr_i     ),
    .lsu_rsp_i           ( lsu_rsp_i           ),
    .lsu_ready_ex_i      ( lsu_ready_ex_i      ),
    .lsu_err_i           ( lsu_err_i           ),
    .mult_ready_i        ( mult_ready          ),
    .branch_in_ex_i      ( branch_in_ex_i      ),
    .wb_ready_i          ( wb_ready_i          ),
    .fw_o                ( regfile_fw_o        ),
    .wb_o                ( regfile_wb_o        ),
    .ex_ready_o          ( ex_ready_o          ),
    .ex_valid_o          ( ex_valid_o          )
  );

endmodule

//--- test/tb_ex_stage.sv
// Random testbench for ex_stage against a behavioral model with seed 93432
// Inputs change on the falling edge and outputs are sampled 5 ns later
module tb_ex_stage import ex_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int SETTLE = 5;
  localparam int MAX_WAIT = 10;

  logic                     clk;
  logic                     rst_n;
  alu_req_t                 alu_req;
  mult_req_t                mult_req;
  logic                     csr_access;
  word_t                    csr_rdata;
  logic                     lsu_en;
  logic                     lsu_ready_ex;
  logic                     lsu_err;
  lsu_rsp_t                 lsu_rsp;
  logic                     branch_in_ex;
  logic                     regfile_alu_we;
  logic [RF_ADDR_WIDTH-1:0] regfile_alu_waddr;
  logic                     regfile_we;
  logic [RF_ADDR_WIDTH-1:0] regfile_waddr;
  logic                     wb_ready;
  rf_wr_t                   fw;
  rf_wr_t                   wb;
  word_t                    jump_target;
  logic                     branch_decision;
  logic                     mult_multicycle;
  logic                     ex_ready;
  logic                     ex_valid;

  integer                   seed = 93432;
  int                       errors = 0;
  int                       checks = 0;
  logic [31:0]              r;
  int                       stalls;
  logic                     prev_we;
  logic [RF_ADDR_WIDTH-1:0] prev_addr;
  logic                     prev_valid;
  logic                     exp_ready;

  ex_stage i_ex_stage (
    .clk                 ( clk               ),
    .rst_n               ( rst_n             ),
    .alu_req_i           ( alu_req           ),
    .mult_req_i          ( mult_req          ),
    .csr_access_i        ( csr_access        ),
    .csr_rdata_i         ( csr_rdata         ),
    .lsu_en_i            ( lsu_en            ),
    .lsu_ready_ex_i      ( lsu_ready_ex      ),
    .lsu_err_i           ( lsu_err           ),
    .lsu_rsp_i           ( lsu_rsp           ),
    .branch_in_ex_i      ( branch_in_ex      ),
    .regfile_alu_we_i    ( regfile_alu_we    ),
    .regfile_alu_waddr_i ( regfile_alu_waddr ),
    .regfile_we_i        ( regfile_we        ),
    .regfile_waddr_i     ( regfile_waddr     ),
    .wb_ready_i          ( wb_ready          ),
    .regfile_fw_o        ( fw                ),
    .regfile_wb_o        ( wb                ),
    .jump_target_o       ( jump_target       ),
    .branch_decision_o   ( branch_decision   ),
    .mult_multicycle_o   ( mult_multicycle   ),
    .ex_ready_o          ( ex_ready          ),
    .ex_valid_o          ( ex_valid          )
  );

  // 40 ns period
  always #20 clk = ~clk;

  ////////////////////
  // Reference model
  ////////////////////

  function automatic logic branch_ref(alu_op_e op, word_t a, word_t b);
    logic lt_s;
    logic lt_u;
    // Signed order by flipping the sign bits
    lt_s = {~a[31], a[30:0]} < {~b[31], b[30:0]};
    lt_u = a < b;
    case (op)
      ALU_EQ:            return a == b;
      ALU_NE:            return a != b;
      ALU_LT, ALU_SLT:   return lt_s;
      ALU_GE:            return !lt_s;
      ALU_LTU, ALU_SLTU: return lt_u;
      ALU_GEU:           return !lt_u;
      default:           return 1'b0;
    endcase
  endfunction

  function automatic word_t alu_ref(alu_op_e op, word_t a, word_t b);
    logic [63:0] ext;
    ext = {{32{a[31]}}, a} >> b[4:0];
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SLL: return a << b[4:0];
      ALU_SRL: return a >> b[4:0];
      ALU_SRA: return ext[31:0];
      default: return {31'b0, branch_ref(op, a, b)};
    endcase
  endfunction

  // Full 64-bit product where the operator picks the extension and the half
  function automatic word_t product_ref(mult_op_e op, word_t a, word_t b);
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] p;
    ea = (op == MULT_MULH || op == MULT_MULHSU) ? {{32{a[31]}}, a} : {32'b0, a};
    eb = (op == MULT_MULH) ? {{32{b[31]}}, b} : {32'b0, b};
    p  = ea * eb;
    return (op == MULT_MUL) ? p[31:0] : p[63:32];
  endfunction

  function automatic logic tag_ref(alu_req_t alu, mult_req_t mult, logic csr);
    if (csr) return 1'b0;
    if (mult.enable) return mult.a.tag | mult.b.tag;
    if (!alu.enable) return 1'b0;
    if (alu.op == ALU_SLL || alu.op == ALU_SRL || alu.op == ALU_SRA) return alu.a.tag;
    return alu.a.tag | alu.b.tag;
  endfunction

  ////////////////////
  // Helpers
  ////////////////////

  task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Quiet decode with WB and LSU ready
  task automatic drive_idle();
    alu_req           = '0;
    mult_req          = '0;
    csr_access        = 1'b0;
    csr_rdata         = '0;
    lsu_en            = 1'b0;
    lsu_ready_ex      = 1'b1;
    lsu_err           = 1'b0;
    lsu_rsp           = '0;
    branch_in_ex      = 1'b0;
    regfile_alu_we    = 1'b0;
    regfile_alu_waddr = '0;
    regfile_we        = 1'b0;
    regfile_waddr     = '0;
    wb_ready          = 1'b1;
  endtask

  // Mostly random operands with the most negative word or minus one mixed in
  task automatic load_mult_req();
    r = $random(seed);
    mult_req.enable = 1'b1;
    mult_req.op     = mult_op_e'(r[1:0]);
    mult_req.a.data = (r[3:2] == 2'd0) ? 32'h8000_0000 : $random(seed);
    mult_req.b.data = (r[5:4] == 2'd0) ? 32'hffff_ffff : $random(seed);
    mult_req.a.tag  = r[6];
    mult_req.b.tag  = r[7];
  endtask

  // Counts cycles with ex_ready low until the multiplier shows its final state
  task automatic wait_finish(output int low_cycles);
    int cycles;
    cycles     = 0;
    low_cycles = 0;
    #SETTLE;
    while (!mult_multicycle && cycles < MAX_WAIT) begin
      if (!ex_ready) low_cycles++;
      @(negedge clk);
      #SETTLE;
      cycles++;
    end
    if (!mult_multicycle) begin
      errors++;
      $display("Timeout at %0t: multiplier never reached its final state", $time);
    end
  endtask

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    drive_idle();
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #SETTLE;
    expect_eq("WB we after reset", wb.we, 0);
    expect_eq("multicycle after reset", mult_multicycle, 0);

    // ALU operations with results in the same cycle
    repeat (200) begin
      @(negedge clk);
      drive_idle();
      r = $random(seed);
      alu_req.enable = 1'b1;
      alu_req.op     = alu_op_e'({1'b0, r[3:0]});
      alu_req.a.data = $random(seed);
      alu_req.b.data = (r[8:7] == 2'd0) ? alu_req.a.data : $random(seed);
      alu_req.c.data = $random(seed);
      alu_req.a.tag  = r[4];
      alu_req.b.tag  = r[5];
      alu_req.c.tag  = r[6];
      regfile_alu_we    = r[9];
      regfile_alu_waddr = r[15:10];
      #SETTLE;
      expect_eq("ALU data", fw.data, alu_ref(alu_req.op, alu_req.a.data, alu_req.b.data));
      expect_eq("ALU tag", fw.tag, tag_ref(alu_req, mult_req, 1'b0));
      expect_eq("FW we", fw.we, regfile_alu_we);
      expect_eq("FW addr", fw.addr, regfile_alu_waddr);
      expect_eq("branch decision", branch_decision,
                branch_ref(alu_req.op, alu_req.a.data, alu_req.b.data));
      expect_eq("jump target", jump_target, alu_req.c.data);
      expect_eq("ALU ex_ready", ex_ready, 1);
    end

    // High products of the multiplier take two stall cycles
    repeat (60) begin
      @(negedge clk);
      drive_idle();
      load_mult_req();
      if (mult_req.op == MULT_MUL) begin
        #SETTLE;
        expect_eq("MUL multicycle", mult_multicycle, 0);
        expect_eq("MUL ex_ready", ex_ready, 1);
      end else begin
        wait_finish(stalls);
        expect_eq("high product stalls", stalls, 2);
        expect_eq("final ex_ready", ex_ready, 1);
      end
      expect_eq("MUL data", fw.data,
                product_ref(mult_req.op, mult_req.a.data, mult_req.b.data));
      expect_eq("MUL tag", fw.tag, tag_ref(alu_req, mult_req, 1'b0));
    end

    // CSR over multiplier over ALU
    repeat (40) begin
      @(negedge clk);
      drive_idle();
      load_mult_req();
      mult_req.op    = MULT_MUL;
      alu_req.enable = 1'b1;
      alu_req.a.data = $random(seed);
      alu_req.a.tag  = 1'b1;
      csr_rdata      = $random(seed);
      csr_access     = r[8];
      #SETTLE;
      if (csr_access) begin
        expect_eq("CSR data", fw.data, csr_rdata);
        expect_eq("CSR tag", fw.tag, 0);
      end else begin
        expect_eq("MUL over ALU", fw.data,
                  product_ref(MULT_MUL, mult_req.a.data, mult_req.b.data));
        expect_eq("MUL over ALU tag", fw.tag, tag_ref(alu_req, mult_req, 1'b0));
      end
    end

    // Back-to-back loads checked on the WB port one cycle later
    prev_valid = 1'b0;
    repeat (40) begin
      @(negedge clk);
      drive_idle();
      r = $random(seed);
      lsu_en        = 1'b1;
      regfile_we    = r[0];
      lsu_err       = r[1] & r[2];
      regfile_waddr = r[10:5];
      lsu_rsp.data  = $random(seed);
      lsu_rsp.tag   = r[3];
      #SETTLE;
      expect_eq("load ex_valid", ex_valid, 1);
      if (prev_valid) begin
        expect_eq("WB we", wb.we, prev_we);
        if (prev_we) expect_eq("WB addr", wb.addr, prev_addr);
      end
      expect_eq("WB data", wb.data, lsu_rsp.data);
      expect_eq("WB tag", wb.tag, lsu_rsp.tag);
      prev_we    = regfile_we & ~lsu_err;
      prev_addr  = regfile_waddr;
      prev_valid = 1'b1;
    end
    @(negedge clk);
    drive_idle();
    #SETTLE;
    expect_eq("last WB we", wb.we, prev_we);
    if (prev_we) expect_eq("last WB addr", wb.addr, prev_addr);
    @(negedge clk);
    #SETTLE;
    expect_eq("drained WB we", wb.we, 0);

    ////////////////////
    // Back-pressure
    ////////////////////

    repeat (100) begin
      @(negedge clk);
      drive_idle();
      r = $random(seed);
      alu_req.enable = r[0];
      csr_access     = r[1];
      lsu_en         = r[2];
      wb_ready       = r[3];
      lsu_ready_ex   = r[4] | r[5];
      branch_in_ex   = r[6];
      exp_ready      = wb_ready & lsu_ready_ex;
      #SETTLE;
      expect_eq("stalled ex_valid", ex_valid, (r[0] | r[1] | r[2]) & exp_ready);
      expect_eq("stalled ex_ready", ex_ready, exp_ready | branch_in_ex);
    end

    // High product held in its final state while WB is not ready
    repeat (8) begin
      @(negedge clk);
      drive_idle();
      load_mult_req();
      mult_req.op = mult_op_e'({r[1:0] == 2'd0, r[0]} | 2'd1);
      wb_ready    = 1'b0;
      wait_finish(stalls);
      expect_eq("held ex_ready", ex_ready, 0);
      expect_eq("held multicycle", mult_multicycle, 1);
      repeat (r[9:8]) begin
        @(negedge clk);
        #SETTLE;
        expect_eq("held ex_ready", ex_ready, 0);
        expect_eq("held multicycle", mult_multicycle, 1);
      end
      @(negedge clk);
      wb_ready = 1'b1;
      #SETTLE;
      expect_eq("released ex_ready", ex_ready, 1);
      expect_eq("held product", fw.data,
                product_ref(mult_req.op, mult_req.a.data, mult_req.b.data));
    end

    @(negedge clk);
    drive_idle();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- ex_stage.f
rtl/ex_pkg.sv
rtl/ex_alu.sv
rtl/ex_mult.sv
rtl/ex_tag_prop.sv
rtl/ex_writeback.sv
rtl/ex_stage.sv
test/tb_ex_stage.sv

//--- Bender.yml
package:
  name: ex_stage

sources:
  # Package first, then the units, then the top level
  - rtl/ex_pkg.sv
  - rtl/ex_alu.sv
  - rtl/ex_mult.sv
  - rtl/ex_tag_prop.sv
  - rtl/ex_writeback.sv
  - rtl/ex_stage.sv

  - target: test
    files:
      - test/tb_ex_stage.sv
